//--- Bender.yml
package:
  name: cdc_stream_bridge

sources:
  # RTL in compile order.
  - files:
      - verilog/cdc_pkg.sv
      - verilog/gray_sync.sv
      - verilog/async_fifo_core.sv
      - verilog/stream_rx_stage.sv
      - verilog/stream_tx_stage.sv
      - verilog/cdc_stream_bridge.sv

  # Testbench, top module tb_cdc_stream_bridge.
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_cdc_stream_bridge.sv

//--- filelist.f
verilog/cdc_pkg.sv
verilog/gray_sync.sv
verilog/async_fifo_core.sv
verilog/stream_rx_stage.sv
verilog/stream_tx_stage.sv
verilog/cdc_stream_bridge.sv
tb/tb_clock_gen.sv
tb/tb_cdc_stream_bridge.sv

//--- tb/tb_cdc_stream_bridge.sv
// =============================
// CDC stream bridge testbench.
// Directed tests with a
// reference queue between the
// rx and tx stream monitors.
// =============================

`timescale 1ns/1ps

module tb_cdc_stream_bridge import cdc_pkg::*; ();

    localparam real RX_PERIOD_NS = 8.0;
    localparam real TX_PERIOD_NS = 11.0;     // Unrelated to the rx clock.
    localparam int  RESET_CYCLES = 10;
    localparam int  WAIT_LIMIT   = 200;      // Cycles for one handshake or flag.
    localparam int  DRAIN_LIMIT  = 4000;     // Tx cycles to empty the queue.
    localparam int  BURST_WORDS  = 64;
    localparam int  RANDOM_WORDS = 200;
    localparam int  PATTERN_SIZE = 1024;     // Length of the tx_tready pattern.
    localparam int  LOW_RUN      = 20;       // Rx cycles of low ready that mean full.

    logic                  areset_n;
    logic                  rx_aclk;
    logic                  rx_tvalid;
    logic [DATA_WIDTH-1:0] rx_tdata;
    logic                  rx_tready;
    logic                  tx_aclk;
    logic                  tx_tvalid;
    logic [DATA_WIDTH-1:0] tx_tdata;
    logic                  tx_tready;

    logic [DATA_WIDTH-1:0] ref_q [$];        // Accepted words not yet seen on tx.
    int     err_count  = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     rx_words   = 0;                  // Rx handshakes so far.
    int     tx_words   = 0;                  // Tx handshakes so far.
    integer seed;

    tb_clock_gen #(.PERIOD_NS(RX_PERIOD_NS)) i_rx_clock_gen (.clk(rx_aclk));
    tb_clock_gen #(.PERIOD_NS(TX_PERIOD_NS)) i_tx_clock_gen (.clk(tx_aclk));

    cdc_stream_bridge i_cdc_stream_bridge (
        .areset_n  (areset_n),
        .rx_aclk   (rx_aclk),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tready (rx_tready),
        .tx_aclk   (tx_aclk),
        .tx_tvalid (tx_tvalid),
        .tx_tdata  (tx_tdata),
        .tx_tready (tx_tready)
    );

    // Sender side. Every accepted rx word becomes an expected tx word.
    always @(posedge rx_aclk) begin
        if (areset_n && rx_tvalid && rx_tready) begin
            ref_q.push_back(rx_tdata);
            rx_words++;
        end
    end

    // Receiver side. Pops and compares on each tx handshake.
    always @(posedge tx_aclk) begin
        if (areset_n && tx_tvalid && tx_tready) begin
            tx_words++;
            if (ref_q.size() == 0) begin
                $display("ERROR %0t ns: extra tx word %h, none outstanding", $time, tx_tdata);
                err_count++;
            end
            else begin
                if (tx_tdata !== ref_q[0]) begin
                    $display("ERROR %0t ns: tx word %h, expected %h", $time, tx_tdata, ref_q[0]);
                    err_count++;
                end
                void'(ref_q.pop_front());
            end
        end
    end

    // Offers one word and returns on the edge that takes it; valid stays high.
    task automatic send_word(input logic [DATA_WIDTH-1:0] word);
        int   cycles;
        logic taken;
        taken = 1'b0;
        @(negedge rx_aclk);
        rx_tvalid = 1'b1;
        rx_tdata  = word;
        for (cycles = 0; cycles < WAIT_LIMIT && !taken; cycles++) begin
            @(posedge rx_aclk);
            taken = (rx_tready === 1'b1);
        end
        if (!taken) begin
            $display("Timed out at %0t ns: rx side never accepted word %h", $time, word);
            err_count++;
        end
    endtask

    task automatic stop_rx();
        @(negedge rx_aclk);
        rx_tvalid = 1'b0;
    endtask

    task automatic set_tx_ready(input logic value);
        @(negedge tx_aclk);
        tx_tready = value;
    endtask

    task automatic wait_drain();
        int cycles;
        for (cycles = 0; cycles < DRAIN_LIMIT && ref_q.size() != 0; cycles++) begin
            @(negedge tx_aclk);
        end
        if (ref_q.size() != 0) begin
            $display("Timed out at %0t ns: %0d words never reached tx", $time, ref_q.size());
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (err_count == errors_before) begin
            pass_count++;
            $display("Test %s: passed", name);
        end
        else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", name, err_count - errors_before);
        end
    endtask

    task automatic reset_state_test();
        int   errors_before;
        int   cycles;
        logic ready_seen;
        errors_before = err_count;
        ready_seen    = 1'b0;
        areset_n      = 1'b0;
        for (cycles = 0; cycles < RESET_CYCLES; cycles++) begin
            @(negedge rx_aclk);
            if (rx_tready !== 1'b0 || tx_tvalid !== 1'b0) begin
                $display("ERROR %0t ns: rx_tready %b tx_tvalid %b in reset",
                         $time, rx_tready, tx_tvalid);
                err_count++;
            end
        end
        areset_n = 1'b1;                     // Released on a falling rx edge.
        for (cycles = 0; cycles < WAIT_LIMIT && !ready_seen; cycles++) begin
            @(negedge rx_aclk);
            ready_seen = (rx_tready === 1'b1);
            if (tx_tvalid !== 1'b0) begin
                $display("ERROR %0t ns: tx_tvalid %b with an empty FIFO", $time, tx_tvalid);
                err_count++;
            end
        end
        if (!ready_seen) begin
            $display("Timed out at %0t ns: rx_tready never rose after reset", $time);
            err_count++;
        end
        report_test("reset state", errors_before);
    endtask

    task automatic single_word_test();
        int errors_before;
        int tx_before;
        errors_before = err_count;
        tx_before     = tx_words;
        set_tx_ready(1'b1);
        send_word(16'h5ac3);
        stop_rx();
        wait_drain();
        repeat (10) @(negedge tx_aclk);      // Quiet period in which nothing more may show up.
        if (tx_tvalid !== 1'b0 || tx_words - tx_before != 1) begin
            $display("ERROR %0t ns: tx_tvalid %b after %0d words, expected one word",
                     $time, tx_tvalid, tx_words - tx_before);
            err_count++;
        end
        report_test("single word", errors_before);
    endtask

    task automatic burst_order_test();
        int errors_before;
        int tx_before;
        int i;
        errors_before = err_count;
        tx_before     = tx_words;
        set_tx_ready(1'b1);
        for (i = 0; i < BURST_WORDS; i++) begin
            send_word(DATA_WIDTH'($random(seed)));  // Back to back with valid held high.
        end
        stop_rx();
        wait_drain();
        repeat (10) @(negedge tx_aclk);
        if (tx_words - tx_before != BURST_WORDS || ref_q.size() != 0) begin
            $display("ERROR %0t ns: %0d burst words on tx, expected %0d",
                     $time, tx_words - tx_before, BURST_WORDS);
            err_count++;
        end
        report_test("burst order", errors_before);
    endtask

    task automatic back_pressure_test();
        int                    errors_before;
        int                    rx_before;
        int                    tx_before;
        int                    accepted;
        int                    low_run;
        int                    cycles;
        int                    steady;
        logic                  taken;
        logic [DATA_WIDTH-1:0] first_word;
        errors_before = err_count;
        rx_before     = rx_words;
        tx_before     = tx_words;
        taken         = 1'b1;
        low_run       = 0;
        set_tx_ready(1'b0);
        for (cycles = 0; cycles < WAIT_LIMIT && low_run < LOW_RUN; cycles++) begin
            @(negedge rx_aclk);
            if (taken) begin
                rx_tdata = DATA_WIDTH'($random(seed));  // New word only after a handshake.
            end
            rx_tvalid = 1'b1;
            @(posedge rx_aclk);
            taken   = (rx_tready === 1'b1);
            low_run = taken ? 0 : low_run + 1;
        end
        stop_rx();
        if (low_run < LOW_RUN) begin
            $display("Timed out at %0t ns: rx_tready never stayed low", $time);
            err_count++;
        end
        accepted = rx_words - rx_before;
        if (accepted < ALMOST_FULL_LEVEL || accepted > FIFO_DEPTH) begin
            $display("ERROR %0t ns: %0d words accepted, expected %0d to %0d",
                     $time, accepted, ALMOST_FULL_LEVEL, FIFO_DEPTH);
            err_count++;
        end
        for (cycles = 0; cycles < WAIT_LIMIT && tx_tvalid !== 1'b1; cycles++) begin
            @(negedge tx_aclk);
        end
        if (tx_tvalid !== 1'b1 || ref_q.size() == 0) begin
            $display("Timed out at %0t ns: tx_tvalid never rose under back-pressure", $time);
            err_count++;
        end
        else begin
            first_word = ref_q[0];           // Oldest accepted word.
            for (steady = 0; steady < 10; steady++) begin
                @(negedge tx_aclk);
                if (tx_tvalid !== 1'b1 || tx_tdata !== first_word) begin
                    $display("ERROR %0t ns: held word %h valid %b, expected %h",
                             $time, tx_tdata, tx_tvalid, first_word);
                    err_count++;
                end
            end
        end
        set_tx_ready(1'b1);
        wait_drain();
        if (tx_words - tx_before != accepted) begin
            $display("ERROR %0t ns: %0d words drained, expected %0d",
                     $time, tx_words - tx_before, accepted);
            err_count++;
        end
        report_test("back-pressure", errors_before);
    endtask

    task automatic random_traffic_test();
        int                    errors_before;
        int                    rx_before;
        int                    tx_before;
        int                    i;
        int                    cycles;
        int                    gaps [RANDOM_WORDS];
        logic [DATA_WIDTH-1:0] words [RANDOM_WORDS];
        logic                  ready_pattern [PATTERN_SIZE];
        logic                  sender_done;
        errors_before = err_count;
        rx_before     = rx_words;
        tx_before     = tx_words;
        sender_done   = 1'b0;
        // Drawn up front so both clock domains see a fixed sequence.
        for (i = 0; i < RANDOM_WORDS; i++) begin
            words[i] = DATA_WIDTH'($random(seed));
            gaps[i]  = $random(seed) & 3;    // Zero to three idle rx cycles.
        end
        for (i = 0; i < PATTERN_SIZE; i++) begin
            ready_pattern[i] = (($random(seed) & 3) != 0);  // Ready about three quarters.
        end
        fork
            begin
                for (i = 0; i < RANDOM_WORDS; i++) begin
                    if (gaps[i] != 0) begin
                        stop_rx();
                        repeat (gaps[i] - 1) @(negedge rx_aclk);
                    end
                    send_word(words[i]);
                end
                stop_rx();
                sender_done = 1'b1;
            end
            begin
                for (cycles = 0; cycles < DRAIN_LIMIT && !sender_done; cycles++) begin
                    @(negedge tx_aclk);
                    tx_tready = ready_pattern[cycles % PATTERN_SIZE];
                end
                if (!sender_done) begin
                    $display("Timed out at %0t ns: rx sender never finished", $time);
                    err_count++;
                end
            end
        join
        set_tx_ready(1'b1);
        wait_drain();
        repeat (10) @(negedge tx_aclk);
        if (rx_words - rx_before != RANDOM_WORDS || tx_words - tx_before != RANDOM_WORDS ||
            ref_q.size() != 0) begin
            $display("ERROR %0t ns: %0d words in, %0d words out, expected %0d",
                     $time, rx_words - rx_before, tx_words - tx_before, RANDOM_WORDS);
            err_count++;
        end
        report_test("random traffic", errors_before);
    endtask

    initial begin
        seed      = 32'h7318_a7ec;
        areset_n  = 1'b0;
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        tx_tready = 1'b0;
        reset_state_test();
        single_word_test();
        burst_order_test();
        back_pressure_test();
        random_traffic_test();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
// =============================
// Testbench clock source.
// Free-running clock with a
// settable period.
// =============================

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0          // Full clock period.
) (
    output logic clk                        // Generated clock.
);

    initial begin
        clk = 1'b0;                         // Starts low, first rising edge at half period.
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

//--- verilog/async_fifo_core.sv
// =============================
// Dual-clock FIFO core.
// Memory, binary and Gray
// pointers, write fill count
// and read empty flag.
// =============================

`timescale 1ns/1ps

module async_fifo_core import cdc_pkg::*; (
    input  logic                  areset_n,     // Shared async reset.
    // Write side.
    input  logic                  rx_aclk,      // Write clock.
    input  logic                  write_en,     // Store write_data this cycle.
    input  logic [DATA_WIDTH-1:0] write_data,   // Word to store.
    output logic [PTR_WIDTH-1:0]  write_used,   // Fill count seen from rx side.
    // Read side.
    input  logic                  tx_aclk,      // Read clock.
    input  logic                  read_en,      // Pop one word.
    output logic [DATA_WIDTH-1:0] read_data,    // Registered read word.
    output logic                  read_empty    // Nothing to read.
);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];    // Storage array.

    logic [PTR_WIDTH-1:0]  wr_ptr_bin;          // Write pointer, binary.
    logic [PTR_WIDTH-1:0]  wr_ptr_next;         // Write pointer plus one.
    logic [PTR_WIDTH-1:0]  wr_ptr_gray;         // Write pointer, Gray.
    logic [PTR_WIDTH-1:0]  wr_gray_sync;        // Write Gray in tx domain.

    logic [PTR_WIDTH-1:0]  rd_ptr_bin;          // Read pointer, binary.
    logic [PTR_WIDTH-1:0]  rd_ptr_next;         // Read pointer plus one.
    logic [PTR_WIDTH-1:0]  rd_ptr_gray;         // Read pointer, Gray.
    logic [PTR_WIDTH-1:0]  rd_gray_sync;        // Read Gray in rx domain.

    function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [PTR_WIDTH-1:0] gray2bin(input logic [PTR_WIDTH-1:0] gray);
        logic [PTR_WIDTH-1:0] bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];   // MSB carries over.
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];        // Running XOR from the top.
        end
        return bin;
    endfunction

    always_comb wr_ptr_next = wr_ptr_bin + 1'b1;
    always_comb rd_ptr_next = rd_ptr_bin + 1'b1;

    // Write domain.
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end
        else if (write_en) begin
            wr_ptr_bin  <= wr_ptr_next;
            wr_ptr_gray <= bin2gray(wr_ptr_next); // Registered, glitch free for the crossing.
        end
    end

    always_ff @(posedge rx_aclk) begin
        if (write_en) begin
            mem[wr_ptr_bin[ADDR_WIDTH-1:0]] <= write_data;
        end
    end

    // Wrap bit keeps a full FIFO apart from an empty one.
    always_comb write_used = wr_ptr_bin - gray2bin(rd_gray_sync);

    // Read domain.
    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end
        else if (read_en) begin
            rd_ptr_bin  <= rd_ptr_next;
            rd_ptr_gray <= bin2gray(rd_ptr_next);
        end
    end

    always_ff @(posedge tx_aclk) begin
        if (read_en) begin
            read_data <= mem[rd_ptr_bin[ADDR_WIDTH-1:0]]; // Holds until next read.
        end
    end

    always_comb read_empty = (wr_gray_sync == rd_ptr_gray); // Equal Gray pointers.

    // Pointer crossings.
    gray_sync i_wr_ptr_sync (
        .clk      (tx_aclk),
        .areset_n (areset_n),
        .gray_in  (wr_ptr_gray),
        .gray_out (wr_gray_sync)
    );

    gray_sync i_rd_ptr_sync (
        .clk      (rx_aclk),
        .areset_n (areset_n),
        .gray_in  (rd_ptr_gray),
        .gray_out (rd_gray_sync)
    );

endmodule

//--- verilog/cdc_pkg.sv
// =============================
// CDC stream bridge package.
// Word width, FIFO geometry and
// the almost-full threshold.
// =============================

package cdc_pkg;

    localparam int DATA_WIDTH = 16;                   // Bits per stream word.

    localparam int FIFO_DEPTH = 16;                   // Storage words, power of two, at least 4.

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);   // Memory address bits.

    localparam int PTR_WIDTH = ADDR_WIDTH + 1;        // Address plus wrap bit.

    // Ready drops here; three slots absorb the registered ready and write strobe.
    localparam logic [PTR_WIDTH-1:0] ALMOST_FULL_LEVEL = PTR_WIDTH'(FIFO_DEPTH - 3);

endpackage

//--- verilog/cdc_stream_bridge.sv
// =============================
// CDC stream bridge top.
// Carries stream words from
// rx_aclk to tx_aclk.
// =============================

`timescale 1ns/1ps

module cdc_stream_bridge import cdc_pkg::*; (
    input  logic                  areset_n,     // Shared async reset.
    // Rx side.
    input  logic                  rx_aclk,
    input  logic                  rx_tvalid,
    input  logic [DATA_WIDTH-1:0] rx_tdata,
    output logic                  rx_tready,
    // Tx side.
    input  logic                  tx_aclk,
    output logic                  tx_tvalid,
    output logic [DATA_WIDTH-1:0] tx_tdata,
    input  logic                  tx_tready
);

    logic                  write_en;            // Rx stage to core.
    logic [DATA_WIDTH-1:0] write_data;
    logic [PTR_WIDTH-1:0]  write_used;          // Core back to rx stage.
    logic                  read_en;             // Tx stage to core.
    logic [DATA_WIDTH-1:0] read_data;
    logic                  read_empty;

    stream_rx_stage i_stream_rx_stage (
        .areset_n   (areset_n),
        .rx_aclk    (rx_aclk),
        .rx_tvalid  (rx_tvalid),
        .rx_tdata   (rx_tdata),
        .rx_tready  (rx_tready),
        .write_en   (write_en),
        .write_data (write_data),
        .write_used (write_used)
    );

    async_fifo_core i_async_fifo_core (
        .areset_n   (areset_n),
        .rx_aclk    (rx_aclk),
        .write_en   (write_en),
        .write_data (write_data),
        .write_used (write_used),
        .tx_aclk    (tx_aclk),
        .read_en    (read_en),
        .read_data  (read_data),
        .read_empty (read_empty)
    );

    stream_tx_stage i_stream_tx_stage (
        .areset_n   (areset_n),
        .tx_aclk    (tx_aclk),
        .tx_tready  (tx_tready),
        .tx_tvalid  (tx_tvalid),
        .tx_tdata   (tx_tdata),
        .read_en    (read_en),
        .read_data  (read_data),
        .read_empty (read_empty)
    );

endmodule

//--- verilog/gray_sync.sv
// =============================
// Gray pointer synchronizer.
// Two flops in the destination
// clock domain.
// =============================

`timescale 1ns/1ps

module gray_sync import cdc_pkg::*; (
    input  logic                 clk,        // Destination clock.
    input  logic                 areset_n,   // Async reset, active low.
    input  logic [PTR_WIDTH-1:0] gray_in,    // Gray pointer from source domain.
    output logic [PTR_WIDTH-1:0] gray_out    // Pointer in destination domain.
);

    logic [PTR_WIDTH-1:0] sync_meta;         // First stage, may go metastable.

    // Only one bit moves per source update, so a late sample is off by one step at most.
    always_ff @(posedge clk or negedge areset_n) begin
        if (!areset_n) begin
            sync_meta <= '0;
            gray_out  <= '0;
        end
        else begin
            sync_meta <= gray_in;            // Capture asynchronous value.
            gray_out  <= sync_meta;          // Settled copy.
        end
    end

endmodule

//--- verilog/stream_rx_stage.sv
// =============================
// Rx stream stage.
// Registers accepted words into
// FIFO writes, ready from fill.
// =============================

`timescale 1ns/1ps

module stream_rx_stage import cdc_pkg::*; (
    input  logic                  areset_n,     // Async reset, active low.
    input  logic                  rx_aclk,      // Rx clock.
    input  logic                  rx_tvalid,    // Source has a word.
    input  logic [DATA_WIDTH-1:0] rx_tdata,     // Source word.
    output logic                  rx_tready,    // Registered ready.
    output logic                  write_en,     // FIFO write strobe.
    output logic [DATA_WIDTH-1:0] write_data,   // FIFO write word.
    input  logic [PTR_WIDTH-1:0]  write_used    // FIFO fill count.
);

    logic almost_full;                          // Fill at or above threshold.

    always_comb almost_full = (write_used >= ALMOST_FULL_LEVEL);

    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_en  <= 1'b0;
            rx_tready <= 1'b0;                  // Low until first edge out of reset.
        end
        else begin
            write_en  <= rx_tvalid && rx_tready; // One cycle behind the handshake.
            rx_tready <= !almost_full;          // Lags fill count by one cycle.
        end
    end

    always_ff @(posedge rx_aclk) begin
        write_data <= rx_tdata;                 // Only used when write_en is set.
    end

endmodule

//--- verilog/stream_tx_stage.sv
// =============================
// Tx stream stage.
// Show-ahead controller over a
// registered FIFO read port.
// =============================

`timescale 1ns/1ps

module stream_tx_stage import cdc_pkg::*; (
    input  logic                  areset_n,     // Async reset, active low.
    input  logic                  tx_aclk,      // Tx clock.
    input  logic                  tx_tready,    // Sink accepts.
    output logic                  tx_tvalid,    // Word on tx_tdata is valid.
    output logic [DATA_WIDTH-1:0] tx_tdata,     // Output word.
    output logic                  read_en,      // FIFO pop.
    input  logic [DATA_WIDTH-1:0] read_data,    // FIFO registered word.
    input  logic                  read_empty    // FIFO has nothing.
);

    typedef enum logic [0:0] {
        STATE_IDLE,                             // No word presented.
        STATE_DATA                              // read_data holds a live word.
    } state_t;

    state_t state;

    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= STATE_IDLE;
        end
        else begin
            unique case (state)
                STATE_IDLE: begin
                    if (!read_empty) begin
                        state <= STATE_DATA;    // Word lands on next edge.
                    end
                end
                STATE_DATA: begin
                    if (tx_tready && read_empty) begin
                        state <= STATE_IDLE;    // Last word taken, nothing behind it.
                    end
                end
            endcase
        end
    end

    always_comb begin
        unique case (state)
            STATE_IDLE: read_en = !read_empty;
            STATE_DATA: read_en = !read_empty && tx_tready; // Refill on handshake.
        endcase
    end

    always_comb tx_tvalid = (state == STATE_DATA);
    always_comb tx_tdata  = read_data;          // Held by the FIFO between reads.

endmodule
